// ==== design/cl_cfg.svh ====
`ifndef CL_CFG_SVH
`define CL_CFG_SVH

// ---------------------------------------------------------------------------
// Identification and status constants
// ---------------------------------------------------------------------------

`define CL_ID0 32'h1d50_6789
`define CL_ID1 32'h1d51_fedc
`define CL_VERSION 32'hee_ee_ee_00

// Upper 20 bits of status0 when debug is off
`define CL_STATUS_TAG 20'ha1111

// ---------------------------------------------------------------------------
// Structure of the block
// ---------------------------------------------------------------------------

// Register stages on every statistics path
`define CL_STAT_STAGES 4

`define CL_NUM_DDR 4
`define CL_NUM_STAT 3
`define CL_NUM_HMC 2

`endif

// ==== design/cl_pkg.sv ====
package cl_pkg;

  // ---------------------------------------------------------------------------
  // DDR statistics channel
  // ---------------------------------------------------------------------------

  // Shell to controller, one request per cycle at most
  typedef struct packed {
    logic        wr;
    logic        rd;
    logic [7:0]  addr;
    logic [31:0] wdata;
  } stat_req_t;

  // Controller to shell
  typedef struct packed {
    logic        ack;
    logic [7:0]  intr;
    logic [31:0] rdata;
  } stat_ack_t;

  // ---------------------------------------------------------------------------
  // Scrubber observation
  // ---------------------------------------------------------------------------

  // Scrubber FSM state as reported by the scrubber
  typedef logic [2:0] scrb_state_t;

  // Current scrub address, full 64-bit memory address
  typedef logic [63:0] scrb_addr_t;

  // Debug memory select from ctl0[30:28]
  typedef logic [2:0] ctl_sel_t;

endpackage

// ==== design/stat_pipe.sv ====
`timescale 1ns/1ps

`include "cl_cfg.svh"

module stat_pipe #(
  parameter type T = cl_pkg::stat_req_t
) (
  input  logic clk,
  input  logic sync_rst_n,
  input  T     in_data,
  output T     out_data
);

  localparam int STAGES = `CL_STAT_STAGES;

  // Stage 0 takes the input, the last stage drives the output
  T stage_q [STAGES];

  always_ff @(posedge clk or negedge sync_rst_n)
  begin
    if (!sync_rst_n)
    begin
      for (int i = 0; i < STAGES; i++)
      begin
        stage_q[i] <= '0;
      end
    end
    else
    begin
      stage_q[0] <= in_data;
      for (int i = 1; i < STAGES; i++)
      begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign out_data = stage_q[STAGES-1];

endmodule

// ==== design/ctl_decode.sv ====
`timescale 1ns/1ps

`include "cl_cfg.svh"

module ctl_decode (
  input  logic                   clk,
  input  logic                   sync_rst_n,
  input  logic [31:0]            ctl0,
  input  logic                   flr_assert,
  output logic [`CL_NUM_DDR-1:0] ddr_scrb_en,
  output logic [`CL_NUM_HMC-1:0] hmc_scrb_en,
  output logic                   dbg_en,
  output cl_pkg::ctl_sel_t       dbg_sel,
  output logic                   flr_done
);

  logic [31:0] ctl0_q;
  logic        flr_q;

  // ---------------------------------------------------------------------------
  // Control word capture
  // ---------------------------------------------------------------------------

  always_ff @(posedge clk or negedge sync_rst_n)
  begin
    if (!sync_rst_n)
      ctl0_q <= 32'd0;
    else
      ctl0_q <= ctl0;
  end

  // DDR2 and DDR3 enables sit swapped in the control word
  assign ddr_scrb_en[0] = ctl0_q[0];
  assign ddr_scrb_en[1] = ctl0_q[1];
  assign ddr_scrb_en[3] = ctl0_q[2];
  assign ddr_scrb_en[2] = ctl0_q[3];

  assign hmc_scrb_en = ctl0_q[5:4];

  // Debug view of status and ID words
  assign dbg_en  = ctl0_q[31];
  assign dbg_sel = ctl0_q[30:28];

  // ---------------------------------------------------------------------------
  // Function-level reset response
  // ---------------------------------------------------------------------------

  always_ff @(posedge clk or negedge sync_rst_n)
  begin
    if (!sync_rst_n)
    begin
      flr_q    <= 1'b0;
      flr_done <= 1'b0;
    end
    else
    begin
      flr_q    <= flr_assert;
      flr_done <= flr_q && !flr_done;   // toggles while request held
    end
  end

endmodule

// ==== design/scrub_status.sv ====
`timescale 1ns/1ps

`include "cl_cfg.svh"

module scrub_status (
  input  logic                   clk,
  input  logic                   sync_rst_n,
  input  logic                   dbg_en,
  input  cl_pkg::ctl_sel_t       dbg_sel,
  input  logic [`CL_NUM_DDR-1:0] scrb_done,
  input  cl_pkg::scrb_state_t    scrb_state [`CL_NUM_DDR],
  input  cl_pkg::scrb_addr_t     scrb_addr [`CL_NUM_DDR],
  input  logic [`CL_NUM_HMC-1:0] hmc_scrb_done,
  input  logic [`CL_NUM_HMC-1:0] hmc_link_up,
  input  logic [2:0]             ddr_ready,
  input  logic                   shell_ddr_ready,
  output logic [31:0]            status0,
  output logic [31:0]            id0,
  output logic [31:0]            id1
);

  logic               shell_rdy_q;
  logic [3:0]         done_nib;
  logic [3:0]         rdy_nib;
  logic [11:0]        low_bits;
  logic [31:0]        status_nxt;
  cl_pkg::scrb_addr_t sel_addr;

  // ---------------------------------------------------------------------------
  // Readiness and done summary
  // ---------------------------------------------------------------------------

  // Shell ready comes from outside the controller, so capture it first
  always_ff @(posedge clk or negedge sync_rst_n)
  begin
    if (!sync_rst_n)
      shell_rdy_q <= 1'b0;
    else
      shell_rdy_q <= shell_ddr_ready;
  end

  assign rdy_nib  = {ddr_ready[2], shell_rdy_q, ddr_ready[1], ddr_ready[0]};
  assign done_nib = {scrb_done[2], scrb_done[3], scrb_done[1], scrb_done[0]};

  // Shared by both status layouts
  assign low_bits = {hmc_scrb_done[1], hmc_scrb_done[0], hmc_link_up[1:0],
                     done_nib, rdy_nib};

  // ---------------------------------------------------------------------------
  // Output word selection
  // ---------------------------------------------------------------------------

  always_comb
  begin
    if (dbg_en)
      status_nxt = {1'b0, scrb_state[2],
                    1'b0, scrb_state[3],
                    1'b0, scrb_state[1],
                    1'b0, scrb_state[0],
                    4'd0, low_bits};
    else
      status_nxt = {`CL_STATUS_TAG, low_bits};
  end

  // Select codes follow the same ddr2/ddr3 swap as the enables
  always_comb
  begin
    case (dbg_sel)
      3'd3:    sel_addr = scrb_addr[2];
      3'd2:    sel_addr = scrb_addr[3];
      3'd1:    sel_addr = scrb_addr[1];
      default: sel_addr = scrb_addr[0];
    endcase
  end

  always_ff @(posedge clk or negedge sync_rst_n)
  begin
    if (!sync_rst_n)
    begin
      status0 <= 32'd0;
      id0     <= 32'd0;
      id1     <= 32'd0;
    end
    else
    begin
      status0 <= status_nxt;
      id0     <= dbg_en ? sel_addr[31:0] : `CL_ID0;
      id1     <= dbg_en ? sel_addr[63:32] : `CL_ID1;
    end
  end

endmodule

// ==== design/cl_shell_ctl_top.sv ====
`timescale 1ns/1ps

`include "cl_cfg.svh"

module cl_shell_ctl_top (
  input  logic                   clk,
  input  logic                   sync_rst_n,

  // Control word and function-level reset
  input  logic [31:0]            ctl0,
  input  logic                   flr_assert,
  output logic                   flr_done,

  // Scrub enables
  output logic [`CL_NUM_DDR-1:0] ddr_scrb_en,
  output logic [`CL_NUM_HMC-1:0] hmc_scrb_en,

  // Scrubber and readiness observation
  input  logic [`CL_NUM_DDR-1:0] scrb_done,
  input  cl_pkg::scrb_state_t    scrb_state [`CL_NUM_DDR],
  input  cl_pkg::scrb_addr_t     scrb_addr [`CL_NUM_DDR],
  input  logic [`CL_NUM_HMC-1:0] hmc_scrb_done,
  input  logic [`CL_NUM_HMC-1:0] hmc_link_up,
  input  logic [2:0]             ddr_ready,
  input  logic                   shell_ddr_ready,

  // Status words toward the shell
  output logic [31:0]            status0,
  output logic [31:0]            status1,
  output logic [31:0]            id0,
  output logic [31:0]            id1,

  // DDR statistics, requests toward the controller, acks back
  input  cl_pkg::stat_req_t      stat_req_in [`CL_NUM_STAT],
  output cl_pkg::stat_req_t      stat_req_out [`CL_NUM_STAT],
  input  cl_pkg::stat_ack_t      stat_ack_in [`CL_NUM_STAT],
  output cl_pkg::stat_ack_t      stat_ack_out [`CL_NUM_STAT]
);

  logic             dbg_en;
  cl_pkg::ctl_sel_t dbg_sel;

  // ---------------------------------------------------------------------------
  // Control decode and status
  // ---------------------------------------------------------------------------

  ctl_decode u_ctl_decode (
    .clk         (clk),
    .sync_rst_n  (sync_rst_n),
    .ctl0        (ctl0),
    .flr_assert  (flr_assert),
    .ddr_scrb_en (ddr_scrb_en),
    .hmc_scrb_en (hmc_scrb_en),
    .dbg_en      (dbg_en),
    .dbg_sel     (dbg_sel),
    .flr_done    (flr_done)
  );

  scrub_status u_scrub_status (
    .clk             (clk),
    .sync_rst_n      (sync_rst_n),
    .dbg_en          (dbg_en),
    .dbg_sel         (dbg_sel),
    .scrb_done       (scrb_done),
    .scrb_state      (scrb_state),
    .scrb_addr       (scrb_addr),
    .hmc_scrb_done   (hmc_scrb_done),
    .hmc_link_up     (hmc_link_up),
    .ddr_ready       (ddr_ready),
    .shell_ddr_ready (shell_ddr_ready),
    .status0         (status0),
    .id0             (id0),
    .id1             (id1)
  );

  assign status1 = `CL_VERSION;

  // ---------------------------------------------------------------------------
  // Statistics pipelines, one request and one ack path per channel
  // ---------------------------------------------------------------------------

  for (genvar ch = 0; ch < `CL_NUM_STAT; ch++)
  begin : g_stat
    stat_pipe #(
      .T(cl_pkg::stat_req_t)
    ) u_req_pipe (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .in_data    (stat_req_in[ch]),
      .out_data   (stat_req_out[ch])
    );

    stat_pipe #(
      .T(cl_pkg::stat_ack_t)
    ) u_ack_pipe (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .in_data    (stat_ack_in[ch]),
      .out_data   (stat_ack_out[ch])
    );
  end

endmodule

// ==== testbench/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter real PERIOD_NS = 8.0
) (
  output logic clk
);

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2.0) clk = ~clk;
  end

endmodule

// ==== testbench/tb_cl_shell_ctl.sv ====
`timescale 1ns/1ps

`include "cl_cfg.svh"

module tb_cl_shell_ctl;

  localparam int RESET_CYCLES   = 16;
  localparam int STAGES         = `CL_STAT_STAGES;
  // Reset, idle, decode, normal status, debug status, statistics, FLR, drain
  localparam int STIM_CYCLES    = RESET_CYCLES + 4 + 200 + 100 + 64 + 200 + 28 + 6;
  localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + 100;

  logic                   clk;
  logic                   sync_rst_n;
  logic [31:0]            ctl0;
  logic                   flr_assert;
  logic                   flr_done;
  logic [`CL_NUM_DDR-1:0] ddr_scrb_en;
  logic [`CL_NUM_HMC-1:0] hmc_scrb_en;
  logic [`CL_NUM_DDR-1:0] scrb_done;
  cl_pkg::scrb_state_t    scrb_state [`CL_NUM_DDR];
  cl_pkg::scrb_addr_t     scrb_addr [`CL_NUM_DDR];
  logic [`CL_NUM_HMC-1:0] hmc_scrb_done;
  logic [`CL_NUM_HMC-1:0] hmc_link_up;
  logic [2:0]             ddr_ready;
  logic                   shell_ddr_ready;
  logic [31:0]            status0;
  logic [31:0]            status1;
  logic [31:0]            id0;
  logic [31:0]            id1;
  cl_pkg::stat_req_t      stat_req_in [`CL_NUM_STAT];
  cl_pkg::stat_req_t      stat_req_out [`CL_NUM_STAT];
  cl_pkg::stat_ack_t      stat_ack_in [`CL_NUM_STAT];
  cl_pkg::stat_ack_t      stat_ack_out [`CL_NUM_STAT];

  // Reference model state, advanced once per cycle
  logic [31:0]       m_ctl_q;
  logic              m_shell_q;
  logic              m_flr_q;
  logic              m_flr_done;
  logic [31:0]       m_status0;
  logic [31:0]       m_id0;
  logic [31:0]       m_id1;
  cl_pkg::stat_req_t m_req [`CL_NUM_STAT][STAGES];
  cl_pkg::stat_ack_t m_ack [`CL_NUM_STAT][STAGES];

  int          error_cnt     = 0;
  int          check_cnt     = 0;
  int unsigned cycle_cnt     = 0;
  logic        timed_out     = 1'b0;
  logic        last_flr_done = 1'b0;

  tb_clk_gen #(.PERIOD_NS(8.0)) u_clk_gen (.clk(clk));

  cl_shell_ctl_top uut (
    .clk             (clk),
    .sync_rst_n      (sync_rst_n),
    .ctl0            (ctl0),
    .flr_assert      (flr_assert),
    .flr_done        (flr_done),
    .ddr_scrb_en     (ddr_scrb_en),
    .hmc_scrb_en     (hmc_scrb_en),
    .scrb_done       (scrb_done),
    .scrb_state      (scrb_state),
    .scrb_addr       (scrb_addr),
    .hmc_scrb_done   (hmc_scrb_done),
    .hmc_link_up     (hmc_link_up),
    .ddr_ready       (ddr_ready),
    .shell_ddr_ready (shell_ddr_ready),
    .status0         (status0),
    .status1         (status1),
    .id0             (id0),
    .id1             (id1),
    .stat_req_in     (stat_req_in),
    .stat_req_out    (stat_req_out),
    .stat_ack_in     (stat_ack_in),
    .stat_ack_out    (stat_ack_out)
  );

  // ---------------------------------------------------------------------------
  // Reference functions
  // ---------------------------------------------------------------------------

  // Returns {hmc[1:0], ddr[3:0]}, ddr2 and ddr3 swapped in the control word
  function automatic logic [5:0] decode_enables(input logic [31:0] ctl);
    return {ctl[5:4], ctl[2], ctl[3], ctl[1], ctl[0]};
  endfunction

  function automatic logic [31:0] expected_status(
    input logic                dbg,
    input logic [3:0]          done,
    input cl_pkg::scrb_state_t st [`CL_NUM_DDR],
    input logic [1:0]          hmc_done,
    input logic [1:0]          link,
    input logic [2:0]          rdy,
    input logic                shell_q
  );
    logic [11:0] low;
    low = {hmc_done[1], hmc_done[0], link, done[2], done[3], done[1], done[0],
           rdy[2], shell_q, rdy[1], rdy[0]};
    if (dbg)
      return {1'b0, st[2], 1'b0, st[3], 1'b0, st[1], 1'b0, st[0], 4'h0, low};
    else
      return {`CL_STATUS_TAG, low};
  endfunction

  function automatic logic [63:0] selected_addr(
    input logic [2:0]         sel,
    input cl_pkg::scrb_addr_t addr [`CL_NUM_DDR]
  );
    case (sel)
      3'd3:    return addr[2];
      3'd2:    return addr[3];
      3'd1:    return addr[1];
      default: return addr[0];
    endcase
  endfunction

  // ---------------------------------------------------------------------------
  // Model and comparison
  // ---------------------------------------------------------------------------

  task automatic report_mismatch(input string msg);
    error_cnt++;
    $display("Mismatch at %0t ns: %s", $time, msg);
  endtask

  task automatic clear_model();
    m_ctl_q    = '0;
    m_shell_q  = 1'b0;
    m_flr_q    = 1'b0;
    m_flr_done = 1'b0;
    m_status0  = '0;
    m_id0      = '0;
    m_id1      = '0;
    for (int ch = 0; ch < `CL_NUM_STAT; ch++)
    begin
      for (int st = 0; st < STAGES; st++)
      begin
        m_req[ch][st] = '0;
        m_ack[ch][st] = '0;
      end
    end
  endtask

  // Inputs seen now are what the DUT captures at the next rising edge
  task automatic advance_model();
    logic [63:0] addr;
    m_status0 = expected_status(m_ctl_q[31], scrb_done, scrb_state, hmc_scrb_done,
                                hmc_link_up, ddr_ready, m_shell_q);
    addr  = selected_addr(m_ctl_q[30:28], scrb_addr);
    m_id0 = m_ctl_q[31] ? addr[31:0] : `CL_ID0;
    m_id1 = m_ctl_q[31] ? addr[63:32] : `CL_ID1;
    m_ctl_q    = ctl0;
    m_shell_q  = shell_ddr_ready;
    m_flr_done = m_flr_q && !m_flr_done;
    m_flr_q    = flr_assert;
    for (int ch = 0; ch < `CL_NUM_STAT; ch++)
    begin
      for (int st = STAGES - 1; st > 0; st--)
      begin
        m_req[ch][st] = m_req[ch][st-1];
        m_ack[ch][st] = m_ack[ch][st-1];
      end
      m_req[ch][0] = stat_req_in[ch];
      m_ack[ch][0] = stat_ack_in[ch];
    end
  endtask

  task automatic compare_outputs();
    logic [5:0] en;
    en = decode_enables(m_ctl_q);
    check_cnt++;
    if (ddr_scrb_en !== en[3:0])
      report_mismatch($sformatf("ddr_scrb_en got %h expected %h", ddr_scrb_en, en[3:0]));
    if (hmc_scrb_en !== en[5:4])
      report_mismatch($sformatf("hmc_scrb_en got %h expected %h", hmc_scrb_en, en[5:4]));
    if (flr_done !== m_flr_done)
      report_mismatch($sformatf("flr_done got %b expected %b", flr_done, m_flr_done));
    if (flr_done && last_flr_done)
      report_mismatch("flr_done high on two cycles in a row");
    if (status0 !== m_status0)
      report_mismatch($sformatf("status0 got %h expected %h", status0, m_status0));
    if (status1 !== `CL_VERSION)
      report_mismatch($sformatf("status1 got %h expected %h", status1, `CL_VERSION));
    if (id0 !== m_id0)
      report_mismatch($sformatf("id0 got %h expected %h", id0, m_id0));
    if (id1 !== m_id1)
      report_mismatch($sformatf("id1 got %h expected %h", id1, m_id1));
    for (int ch = 0; ch < `CL_NUM_STAT; ch++)
    begin
      if (stat_req_out[ch] !== m_req[ch][STAGES-1])
        report_mismatch($sformatf("stat_req_out[%0d] got %h expected %h",
                                  ch, stat_req_out[ch], m_req[ch][STAGES-1]));
      if (stat_ack_out[ch] !== m_ack[ch][STAGES-1])
        report_mismatch($sformatf("stat_ack_out[%0d] got %h expected %h",
                                  ch, stat_ack_out[ch], m_ack[ch][STAGES-1]));
    end
    last_flr_done = flr_done;
  endtask

  // Outputs are settled mid-cycle, inputs change 1 ns after the rising edge
  always @(negedge clk)
  begin
    if (!sync_rst_n)
      clear_model();
    compare_outputs();
    if (sync_rst_n)
      advance_model();
  end

  always @(posedge clk)
    cycle_cnt <= cycle_cnt + 1;

  // ---------------------------------------------------------------------------
  // Stimulus
  // ---------------------------------------------------------------------------

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic set_idle_inputs();
    ctl0            = '0;
    flr_assert      = 1'b0;
    scrb_done       = '0;
    hmc_scrb_done   = '0;
    hmc_link_up     = '0;
    ddr_ready       = '0;
    shell_ddr_ready = 1'b0;
    for (int i = 0; i < `CL_NUM_DDR; i++)
    begin
      scrb_state[i] = '0;
      scrb_addr[i]  = '0;
    end
    for (int ch = 0; ch < `CL_NUM_STAT; ch++)
    begin
      stat_req_in[ch] = '0;
      stat_ack_in[ch] = '0;
    end
  endtask

  task automatic randomize_status_inputs();
    scrb_done       = 4'($urandom);
    hmc_scrb_done   = 2'($urandom);
    hmc_link_up     = 2'($urandom);
    ddr_ready       = 3'($urandom);
    shell_ddr_ready = 1'($urandom);
    for (int i = 0; i < `CL_NUM_DDR; i++)
    begin
      scrb_state[i] = 3'($urandom);
      scrb_addr[i]  = {32'($urandom), 32'($urandom)};
    end
  endtask

  task automatic randomize_stat_inputs();
    for (int ch = 0; ch < `CL_NUM_STAT; ch++)
    begin
      stat_req_in[ch] = {1'($urandom), 1'($urandom), 8'($urandom), 32'($urandom)};
      stat_ack_in[ch] = {1'($urandom), 8'($urandom), 32'($urandom)};
    end
  endtask

  task automatic check_reset_state();
    if (ddr_scrb_en !== '0 || hmc_scrb_en !== '0 || flr_done !== 1'b0)
      report_mismatch("enables or flr_done not zero after reset");
    if (status0 !== '0 || id0 !== '0 || id1 !== '0)
      report_mismatch("status0 or ID words not zero after reset");
    if (status1 !== `CL_VERSION)
      report_mismatch($sformatf("status1 got %h after reset", status1));
    for (int ch = 0; ch < `CL_NUM_STAT; ch++)
    begin
      if (stat_req_out[ch].wr || stat_req_out[ch].rd || stat_ack_out[ch].ack)
        report_mismatch($sformatf("statistics strobe set after reset on channel %0d", ch));
    end
  endtask

  task automatic end_run();
    $display("Summary: %0d cycles checked, %0d errors", check_cnt, error_cnt);
    if (error_cnt == 0 && !timed_out)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  endtask

  initial
  begin
    void'($urandom(32'h95ea_ae7e));
    sync_rst_n = 1'b0;
    set_idle_inputs();

    // Busy inputs during reset must not reach any output
    ctl0       = '1;
    flr_assert = 1'b1;
    randomize_status_inputs();
    for (int ch = 0; ch < `CL_NUM_STAT; ch++)
    begin
      stat_req_in[ch] = '1;
      stat_ack_in[ch] = '1;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    sync_rst_n = 1'b1;
    check_reset_state();
    set_idle_inputs();
    repeat (4) next_cycle();

    // Random control words, decode and status together
    repeat (200)
    begin
      ctl0 = $urandom;
      randomize_status_inputs();
      next_cycle();
    end

    // Normal status layout
    repeat (100)
    begin
      ctl0 = {1'b0, 31'($urandom)};
      randomize_status_inputs();
      next_cycle();
    end

    // Debug layout for every select code
    for (int sel = 0; sel < 8; sel++)
    begin
      repeat (8)
      begin
        ctl0 = {1'b1, 3'(sel), 28'($urandom)};
        randomize_status_inputs();
        next_cycle();
      end
    end

    // Statistics traffic, back-to-back items included
    ctl0 = '0;
    repeat (200)
    begin
      randomize_stat_inputs();
      next_cycle();
    end
    for (int ch = 0; ch < `CL_NUM_STAT; ch++)
    begin
      stat_req_in[ch] = '0;
      stat_ack_in[ch] = '0;
    end

    // Single FLR request, then a held one
    repeat (5) next_cycle();
    flr_assert = 1'b1;
    next_cycle();
    flr_assert = 1'b0;
    repeat (6) next_cycle();
    flr_assert = 1'b1;
    repeat (10) next_cycle();
    flr_assert = 1'b0;
    repeat (6) next_cycle();

    repeat (6) next_cycle();
    end_run();
  end

  initial
  begin
    wait (cycle_cnt >= TIMEOUT_CYCLES);
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    timed_out = 1'b1;
    end_run();
  end

endmodule

// ==== filelist.f ====
+incdir+design
design/cl_pkg.sv
design/stat_pipe.sv
design/ctl_decode.sv
design/scrub_status.sv
design/cl_shell_ctl_top.sv
testbench/tb_clk_gen.sv
testbench/tb_cl_shell_ctl.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_cl_shell_ctl
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard design/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source, header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "tests failed" $(LOG); then \
	  echo "Simulation FAILED, see $(LOG)"; exit 1; \
	else \
	  echo "Simulation finished, see $(LOG)"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
